// ==== design/sh_defines.svh ====
`ifndef SH_DEFINES_SVH
`define SH_DEFINES_SVH

// Datapath and instruction widths
`define SH_XLEN 32
`define SH_ILEN 16

// General register file
`define SH_NREGS 16
`define SH_RAW 4

// First fetch address after reset
`define SH_RESET_PC 32'h0000_0000

// Code that retires without side effects
`define SH_NOP_IR 16'h0009

`endif

// ==== design/sh_pkg.sv ====
`default_nettype none

`include "sh_defines.svh"

package sh_pkg;

	// Execute operation
	typedef enum logic [3:0] {
		ADD   = 4'd0,
		SUB   = 4'd1,
		AND   = 4'd2,
		OR    = 4'd3,
		XOR   = 4'd4,
		PASS  = 4'd5,
		SHLL  = 4'd6,
		SHLR  = 4'd7,
		CMPEQ = 4'd8,
		MOVT  = 4'd9
	} alu_op_e;

	// Encoding matches bits 1:0 of the MOV.x codes
	typedef enum logic [1:0] {
		BYTE = 2'd0,
		WORD = 2'd1,
		LONG = 2'd2
	} mem_size_e;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		FETCH = 2'd1,
		DATA  = 2'd2
	} seq_state_e;

	// One decoded instruction, carried from ID into EX
	typedef struct packed {
		logic [`SH_ILEN-1:0] ir;
		alu_op_e             op;
		mem_size_e           size;
		logic [`SH_RAW-1:0]  rn;
		logic [`SH_RAW-1:0]  rm;
		logic [`SH_XLEN-1:0] imm;
		logic                use_imm;
		logic                reg_we;
		logic                mem_rd;
		logic                mem_wr;
		logic                t_we;
		logic                illegal;
	} dec_instr_t;

endpackage

`default_nettype wire

// ==== design/sh_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_defines.svh"

// Instruction fetch request, one word per access
interface sh_fetch_if;
	logic                req;
	logic [`SH_XLEN-1:0] addr;
	logic [`SH_XLEN-1:0] rdata;
	logic                done;

	modport pc (output req, output addr, input rdata, input done);
	modport seq (input req, input addr, output rdata, output done);
endinterface

// Data access from EX, lanes are big-endian byte enables
interface sh_mem_if;
	logic                req;
	logic                wr;
	logic [`SH_XLEN-1:0] addr;
	logic [`SH_XLEN-1:0] wdata;
	logic [3:0]          lanes;
	logic [`SH_XLEN-1:0] rdata;
	logic                done;

	modport exec (
		output req, output wr, output addr, output wdata, output lanes,
		input rdata, input done
	);
	modport seq (
		input req, input wr, input addr, input wdata, input lanes,
		output rdata, output done
	);
endinterface

`default_nettype wire

// ==== design/sh_bus_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_defines.svh"

module sh_bus_seq (
	input  logic                CLK,
	input  logic                RST_N,
	sh_fetch_if.seq             fetch,
	sh_mem_if.seq               mem,
	output logic [`SH_XLEN-1:0] bus_a,
	output logic [`SH_XLEN-1:0] bus_do,
	output logic [3:0]          bus_ba,
	output logic                bus_wr,
	output logic                bus_req,
	input  logic [`SH_XLEN-1:0] bus_di,
	input  logic                bus_wait
);
	sh_pkg::seq_state_e state;
	sh_pkg::seq_state_e state_nx;
	logic               data_sel;
	logic               done;

	assign done = bus_req & ~bus_wait;

	// Data wins over fetch; the requester just served is never restarted
	always_comb begin
		state_nx = state;
		case (state)
			sh_pkg::IDLE: begin
				if (mem.req)
					state_nx = sh_pkg::DATA;
				else if (fetch.req)
					state_nx = sh_pkg::FETCH;
			end
			sh_pkg::FETCH: begin
				if (done)
					state_nx = mem.req ? sh_pkg::DATA : sh_pkg::IDLE;
			end
			sh_pkg::DATA: begin
				if (done)
					state_nx = fetch.req ? sh_pkg::FETCH : sh_pkg::IDLE;
			end
			default: state_nx = sh_pkg::IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			state <= sh_pkg::IDLE;
		else
			state <= state_nx;
	end

	// Bus driven from the granted requester
	assign data_sel = (state == sh_pkg::DATA);
	assign bus_req  = (state != sh_pkg::IDLE);
	assign bus_a    = data_sel ? mem.addr : fetch.addr;
	assign bus_do   = mem.wdata;
	assign bus_ba   = data_sel ? mem.lanes : 4'b1111;
	assign bus_wr   = data_sel & mem.wr;

	assign fetch.done  = (state == sh_pkg::FETCH) & ~bus_wait;
	assign fetch.rdata = bus_di;
	assign mem.done    = data_sel & ~bus_wait;
	assign mem.rdata   = bus_di;

endmodule

`default_nettype wire

// ==== design/sh_pc.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_defines.svh"

module sh_pc (
	input  logic                CLK,
	input  logic                RST_N,
	sh_fetch_if.pc              fetch,
	output logic                if_valid,
	output logic [`SH_ILEN-1:0] if_ir,
	input  logic                if_take
);
	logic [`SH_XLEN-1:0] pc;
	logic [`SH_ILEN-1:0] hi_q;
	logic [`SH_ILEN-1:0] lo_q;
	logic                word_ok;

	//*********************************************************************
	// Program counter and buffer state
	//*********************************************************************
	// Odd halfword is served from the buffer, so only a take at an odd
	// address empties it
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pc      <= `SH_RESET_PC;
			word_ok <= 1'b0;
		end else begin
			if (fetch.done)
				word_ok <= 1'b1;
			else if (if_take && pc[1])
				word_ok <= 1'b0;
			if (if_take)
				pc <= pc + `SH_XLEN'd2;
		end
	end

	// Big-endian word, even halfword in the upper half
	always_ff @(posedge CLK) begin
		if (fetch.done) begin
			hi_q <= fetch.rdata[31:16];
			lo_q <= fetch.rdata[15:0];
		end
	end

	//*********************************************************************
	// Fetch request and IF output
	//*********************************************************************
	assign fetch.req  = ~word_ok & ~pc[1];
	assign fetch.addr = {pc[`SH_XLEN-1:2], 2'b00};

	assign if_valid = word_ok;

	always_comb begin
		if (!word_ok)
			if_ir = `SH_NOP_IR;
		else if (pc[1])
			if_ir = lo_q;
		else
			if_ir = hi_q;
	end

endmodule

`default_nettype wire

// ==== design/sh_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_defines.svh"

module sh_decoder (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                if_valid,
	input  logic [`SH_ILEN-1:0] if_ir,
	output logic                if_take,
	output logic [`SH_RAW-1:0]  ra_n,
	output logic [`SH_RAW-1:0]  rb_n,
	input  logic [`SH_XLEN-1:0] ra_q,
	input  logic [`SH_XLEN-1:0] rb_q,
	output logic                ex_valid,
	output sh_pkg::dec_instr_t  ex_instr,
	output logic [`SH_XLEN-1:0] ex_a,
	output logic [`SH_XLEN-1:0] ex_b,
	input  logic                ex_stall,
	output logic                ili
);
	sh_pkg::dec_instr_t dec;

	//*********************************************************************
	// Instruction decode
	//*********************************************************************
	always_comb begin
		dec      = '0;
		dec.ir   = if_ir;
		dec.op   = sh_pkg::PASS;
		dec.size = sh_pkg::LONG;
		dec.rn   = if_ir[11:8];
		dec.rm   = if_ir[7:4];
		dec.imm  = {{24{if_ir[7]}}, if_ir[7:0]};
		case (if_ir[15:12])
			4'h0: begin
				if (if_ir[7:0] == 8'h29) begin
					dec.op     = sh_pkg::MOVT;
					dec.reg_we = 1'b1;
				end else if (if_ir != `SH_NOP_IR) begin
					dec.illegal = 1'b1;
				end
			end
			4'h2: begin
				// MOV.x Rm,@Rn and the logic group
				case (if_ir[3:0])
					4'h9: dec.op = sh_pkg::AND;
					4'hA: dec.op = sh_pkg::XOR;
					4'hB: dec.op = sh_pkg::OR;
					default: ;
				endcase
				dec.reg_we  = (if_ir[3:0] >= 4'h9) && (if_ir[3:0] <= 4'hB);
				dec.mem_wr  = (if_ir[3:0] <= 4'h2);
				dec.illegal = ~dec.reg_we & ~dec.mem_wr;
				if (dec.mem_wr)
					dec.size = sh_pkg::mem_size_e'(if_ir[1:0]);
			end
			4'h3: begin
				case (if_ir[3:0])
					4'h0: begin
						dec.op   = sh_pkg::CMPEQ;
						dec.t_we = 1'b1;
					end
					4'h8: begin
						dec.op     = sh_pkg::SUB;
						dec.reg_we = 1'b1;
					end
					4'hC: begin
						dec.op     = sh_pkg::ADD;
						dec.reg_we = 1'b1;
					end
					default: dec.illegal = 1'b1;
				endcase
			end
			4'h4: begin
				// Shifted-out bit goes to T
				dec.reg_we  = (if_ir[7:1] == 7'h00);
				dec.t_we    = dec.reg_we;
				dec.op      = if_ir[0] ? sh_pkg::SHLR : sh_pkg::SHLL;
				dec.illegal = ~dec.reg_we;
			end
			4'h6: begin
				// MOV.x @Rm,Rn and MOV Rm,Rn
				dec.mem_rd  = (if_ir[3:0] <= 4'h2);
				dec.reg_we  = (if_ir[3:0] <= 4'h3);
				dec.illegal = ~dec.reg_we;
				if (dec.mem_rd)
					dec.size = sh_pkg::mem_size_e'(if_ir[1:0]);
			end
			4'h7: begin
				dec.op      = sh_pkg::ADD;
				dec.use_imm = 1'b1;
				dec.reg_we  = 1'b1;
			end
			4'hE: begin
				dec.use_imm = 1'b1;
				dec.reg_we  = 1'b1;
			end
			default: dec.illegal = 1'b1;
		endcase
		// Illegal codes retire as NOP
		if (dec.illegal)
			dec.ir = `SH_NOP_IR;
	end

	assign ra_n = dec.rn;
	assign rb_n = dec.rm;

	assign if_take = if_valid & ~ex_stall;
	assign ili     = if_take & dec.illegal;

	//*********************************************************************
	// ID/EX register
	//*********************************************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			ex_valid <= 1'b0;
		else if (!ex_stall)
			ex_valid <= if_valid;
	end

	always_ff @(posedge CLK) begin
		if (!ex_stall) begin
			ex_instr <= dec;
			ex_a     <= ra_q;
			ex_b     <= rb_q;
		end
	end

endmodule

`default_nettype wire

// ==== design/sh_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_defines.svh"

module sh_regfile (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic [`SH_RAW-1:0]  ra_n,
	input  logic [`SH_RAW-1:0]  rb_n,
	output logic [`SH_XLEN-1:0] ra_q,
	output logic [`SH_XLEN-1:0] rb_q,
	input  logic [`SH_RAW-1:0]  wr_n,
	input  logic [`SH_XLEN-1:0] wr_d,
	input  logic                wr_en
);
	logic [`SH_XLEN-1:0] regs [`SH_NREGS];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < `SH_NREGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_n] <= wr_d;
		end
	end

	// Write-first, the EX result is visible to ID in the same cycle
	assign ra_q = (wr_en && (wr_n == ra_n)) ? wr_d : regs[ra_n];
	assign rb_q = (wr_en && (wr_n == rb_n)) ? wr_d : regs[rb_n];

endmodule

`default_nettype wire

// ==== design/sh_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_defines.svh"

module sh_execute (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                ex_valid,
	input  sh_pkg::dec_instr_t  ex_instr,
	input  logic [`SH_XLEN-1:0] ex_a,
	input  logic [`SH_XLEN-1:0] ex_b,
	output logic                ex_stall,
	sh_mem_if.exec              mem,
	output logic [`SH_RAW-1:0]  wr_n,
	output logic [`SH_XLEN-1:0] wr_d,
	output logic                wr_en,
	output logic                retire_valid,
	output logic [`SH_ILEN-1:0] retire_ir
);
	logic [`SH_XLEN-1:0] opb;
	logic [`SH_XLEN-1:0] alu_res;
	logic [`SH_XLEN-1:0] addr;
	logic [`SH_XLEN-1:0] shifted;
	logic [`SH_XLEN-1:0] ld_data;
	logic                t_q;
	logic                t_nx;
	logic                is_mem;
	logic                fin;

	//*********************************************************************
	// ALU and T bit
	//*********************************************************************
	assign opb = ex_instr.use_imm ? ex_instr.imm : ex_b;

	always_comb begin
		alu_res = opb;
		t_nx    = t_q;
		case (ex_instr.op)
			sh_pkg::ADD:   alu_res = ex_a + opb;
			sh_pkg::SUB:   alu_res = ex_a - opb;
			sh_pkg::AND:   alu_res = ex_a & opb;
			sh_pkg::OR:    alu_res = ex_a | opb;
			sh_pkg::XOR:   alu_res = ex_a ^ opb;
			sh_pkg::SHLL: begin
				alu_res = {ex_a[`SH_XLEN-2:0], 1'b0};
				t_nx    = ex_a[`SH_XLEN-1];
			end
			sh_pkg::SHLR: begin
				alu_res = {1'b0, ex_a[`SH_XLEN-1:1]};
				t_nx    = ex_a[0];
			end
			sh_pkg::CMPEQ: t_nx = (ex_a == opb);
			sh_pkg::MOVT:  alu_res = {{(`SH_XLEN-1){1'b0}}, t_q};
			default: ;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			t_q <= 1'b0;
		else if (fin && ex_instr.t_we)
			t_q <= t_nx;
	end

	//*********************************************************************
	// Data access
	//*********************************************************************
	// Stores address through Rn, loads through Rm
	assign is_mem   = ex_valid & (ex_instr.mem_rd | ex_instr.mem_wr);
	assign addr     = ex_instr.mem_wr ? ex_a : ex_b;
	assign mem.req  = is_mem;
	assign mem.wr   = ex_instr.mem_wr;
	assign mem.addr = addr;
	assign ex_stall = is_mem & ~mem.done;

	// Offset 0 sits in lane 3, bits 31:24
	always_comb begin
		case (ex_instr.size)
			sh_pkg::BYTE: begin
				mem.lanes = 4'b1000 >> addr[1:0];
				mem.wdata = {4{ex_b[7:0]}};
				shifted   = mem.rdata >> {~addr[1:0], 3'b000};
				ld_data   = {{24{shifted[7]}}, shifted[7:0]};
			end
			sh_pkg::WORD: begin
				mem.lanes = addr[1] ? 4'b0011 : 4'b1100;
				mem.wdata = {2{ex_b[15:0]}};
				shifted   = mem.rdata >> {~addr[1], 4'b0000};
				ld_data   = {{16{shifted[15]}}, shifted[15:0]};
			end
			default: begin
				mem.lanes = 4'b1111;
				mem.wdata = ex_b;
				shifted   = mem.rdata;
				ld_data   = shifted;
			end
		endcase
	end

	// Writeback and retire
	assign fin          = ex_valid & ~ex_stall;
	assign wr_en        = fin & ex_instr.reg_we;
	assign wr_n         = ex_instr.rn;
	assign wr_d         = ex_instr.mem_rd ? ld_data : alu_res;
	assign retire_valid = fin;
	assign retire_ir    = ex_instr.ir;

endmodule

`default_nettype wire

// ==== design/sh_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_defines.svh"

module sh_core (
	input  logic                CLK,
	input  logic                RST_N,
	output logic [`SH_XLEN-1:0] bus_a,
	output logic [`SH_XLEN-1:0] bus_do,
	output logic [3:0]          bus_ba,
	output logic                bus_wr,
	output logic                bus_req,
	input  logic [`SH_XLEN-1:0] bus_di,
	input  logic                bus_wait,
	output logic                ili,
	output logic                retire_valid,
	output logic [`SH_ILEN-1:0] retire_ir
);
	logic                if_valid;
	logic [`SH_ILEN-1:0] if_ir;
	logic                if_take;
	logic [`SH_RAW-1:0]  ra_n;
	logic [`SH_RAW-1:0]  rb_n;
	logic [`SH_XLEN-1:0] ra_q;
	logic [`SH_XLEN-1:0] rb_q;
	logic                ex_valid;
	sh_pkg::dec_instr_t  ex_instr;
	logic [`SH_XLEN-1:0] ex_a;
	logic [`SH_XLEN-1:0] ex_b;
	logic                ex_stall;
	logic [`SH_RAW-1:0]  wr_n;
	logic [`SH_XLEN-1:0] wr_d;
	logic                wr_en;

	sh_fetch_if fetch_bus ();
	sh_mem_if   mem_bus ();

	//*********************************************************************
	// Bus side
	//*********************************************************************
	sh_bus_seq u_seq (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.fetch    (fetch_bus),
		.mem      (mem_bus),
		.bus_a    (bus_a),
		.bus_do   (bus_do),
		.bus_ba   (bus_ba),
		.bus_wr   (bus_wr),
		.bus_req  (bus_req),
		.bus_di   (bus_di),
		.bus_wait (bus_wait)
	);

	//*********************************************************************
	// Pipeline
	//*********************************************************************
	sh_pc u_pc (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.fetch    (fetch_bus),
		.if_valid (if_valid),
		.if_ir    (if_ir),
		.if_take  (if_take)
	);

	sh_decoder u_dec (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.if_valid (if_valid),
		.if_ir    (if_ir),
		.if_take  (if_take),
		.ra_n     (ra_n),
		.rb_n     (rb_n),
		.ra_q     (ra_q),
		.rb_q     (rb_q),
		.ex_valid (ex_valid),
		.ex_instr (ex_instr),
		.ex_a     (ex_a),
		.ex_b     (ex_b),
		.ex_stall (ex_stall),
		.ili      (ili)
	);

	sh_regfile u_regs (
		.CLK   (CLK),
		.RST_N (RST_N),
		.ra_n  (ra_n),
		.rb_n  (rb_n),
		.ra_q  (ra_q),
		.rb_q  (rb_q),
		.wr_n  (wr_n),
		.wr_d  (wr_d),
		.wr_en (wr_en)
	);

	sh_execute u_ex (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.ex_valid     (ex_valid),
		.ex_instr     (ex_instr),
		.ex_a         (ex_a),
		.ex_b         (ex_b),
		.ex_stall     (ex_stall),
		.mem          (mem_bus),
		.wr_n         (wr_n),
		.wr_d         (wr_d),
		.wr_en        (wr_en),
		.retire_valid (retire_valid),
		.retire_ir    (retire_ir)
	);

endmodule

`default_nettype wire

// ==== test/sh_core_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_defines.svh"

module sh_core_asserts (
	input logic                CLK,
	input logic                RST_N,
	input logic                bus_req,
	input logic                bus_wr,
	input logic                bus_wait,
	input logic [`SH_XLEN-1:0] bus_a,
	input logic [3:0]          bus_ba
);
	int fail_cnt = 0;

	// Writes only inside an access
	wr_in_req: assert property (@(posedge CLK) disable iff (!RST_N)
		bus_wr |-> bus_req)
		else begin
			$error("bus_wr without bus_req");
			fail_cnt++;
		end

	// A stretched access keeps its address, lanes and direction
	hold_on_wait: assert property (@(posedge CLK) disable iff (!RST_N)
		(bus_req && bus_wait) |=> ($stable(bus_a) && $stable(bus_ba) && $stable(bus_wr)))
		else begin
			$error("bus request changed during wait");
			fail_cnt++;
		end

	lanes_on_wr: assert property (@(posedge CLK) disable iff (!RST_N)
		(bus_req && bus_wr) |-> (bus_ba != 4'b0000))
		else begin
			$error("write with no byte lane");
			fail_cnt++;
		end

endmodule

bind sh_core sh_core_asserts u_asserts (.*);

`default_nettype wire

// ==== test/sh_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sh_defines.svh"

module sh_core_tb;
	localparam int PROG_LEN  = 74;
	localparam int NSTORES   = 21;
	localparam int NILL      = 3;
	localparam int MEM_WORDS = 128;
	localparam int WAIT_MAX  = 3;
	localparam int NPASS     = 2;
	localparam int LIMIT_CYC = 2 * PROG_LEN * (WAIT_MAX + 3) + 20;

	logic                CLK;
	logic                RST_N;
	logic [`SH_XLEN-1:0] bus_a;
	logic [`SH_XLEN-1:0] bus_do;
	logic [3:0]          bus_ba;
	logic                bus_wr;
	logic                bus_req;
	logic [`SH_XLEN-1:0] bus_di;
	logic                bus_wait;
	logic                ili;
	logic                retire_valid;
	logic [`SH_ILEN-1:0] retire_ir;

	logic [15:0]         prog_ir [PROG_LEN];
	int                  ill_idx [NILL];
	logic [67:0]         st_tab [NSTORES];
	logic [31:0]         mem [MEM_WORDS];

	integer seed;
	int     store_errs;
	int     retire_errs;
	int     other_errs;
	int     st_idx;
	int     ret_cnt;
	int     ili_cnt;
	int     cyc;
	int     wait_run;
	int     pass;
	int     first_ret;
	logic   running;
	logic   rand_waits;

	sh_core dut (.*);

	assign bus_di = mem[bus_a[8:2]];

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	//*********************************************************************
	// Program and expected stores
	//*********************************************************************
	task automatic load_tables();
		prog_ir = '{
			16'hEE40, 16'h4E00, 16'h4E00, 16'hE17B, 16'hFFFD, 16'h2E12, 16'h7E04, 16'hE2F0,
			16'h321C, 16'h2E22, 16'h7E04, 16'h3218, 16'h2E22, 16'h7E04, 16'hE355, 16'h2329,
			16'h2E32, 16'h7E04, 16'h231B, 16'h2E32, 16'h7E04, 16'h232A, 16'h2E32, 16'h7E04,
			16'h4300, 16'h2E32, 16'h7E04, 16'h4301, 16'h2E32, 16'h7E04, 16'hE4A5, 16'h65E3,
			16'h4E10, 16'h2540, 16'h7501, 16'h2540, 16'h7501, 16'h2540, 16'h7501, 16'h2540,
			16'h7E04, 16'h2E31, 16'h7E02, 16'h2E31, 16'h7E02, 16'h67E3, 16'h77F4, 16'h6870,
			16'h2E82, 16'h7E04, 16'h7703, 16'h6870, 16'h2E82, 16'h7E04, 16'h77FD, 16'h6871,
			16'h2E82, 16'h7E04, 16'h7702, 16'h6871, 16'h2E82, 16'h7E04, 16'h77EA, 16'h2003,
			16'h6872, 16'h2E82, 16'h7E04, 16'h3110, 16'h0929, 16'h2E92, 16'h7E04, 16'h3120,
			16'h0929, 16'h2E92
		};
		ill_idx = '{4, 32, 63};
		// Columns are address, data, lanes
		st_tab = '{
			{32'h100, 32'h0000007B, 4'hF},
			{32'h104, 32'h0000006B, 4'hF},
			{32'h108, 32'hFFFFFFF0, 4'hF},
			{32'h10C, 32'h00000050, 4'hF},
			{32'h110, 32'h0000007B, 4'hF},
			{32'h114, 32'hFFFFFF8B, 4'hF},
			{32'h118, 32'hFFFFFF16, 4'hF},
			{32'h11C, 32'h7FFFFF8B, 4'hF},
			{32'h120, 32'hA5A5A5A5, 4'h8},
			{32'h121, 32'hA5A5A5A5, 4'h4},
			{32'h122, 32'hA5A5A5A5, 4'h2},
			{32'h123, 32'hA5A5A5A5, 4'h1},
			{32'h124, 32'hFF8BFF8B, 4'hC},
			{32'h126, 32'hFF8BFF8B, 4'h3},
			{32'h128, 32'h0000007F, 4'hF},
			{32'h12C, 32'hFFFFFF8B, 4'hF},
			{32'h130, 32'h00007FFF, 4'hF},
			{32'h134, 32'hFFFFFF8B, 4'hF},
			{32'h138, 32'hFFFFFFF0, 4'hF},
			{32'h13C, 32'h00000001, 4'hF},
			{32'h140, 32'h00000000, 4'hF}
		};
	endtask

	function automatic logic is_illegal(input int k);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < NILL; i++)
			if (ill_idx[i] == k)
				hit = 1'b1;
		return hit;
	endfunction

	function automatic string store_group(input int k);
		if (k < 8)
			return "alu";
		else if (k < 14)
			return "align";
		else if (k < 19)
			return "load";
		return "cmp_movt";
	endfunction

	//*********************************************************************
	// Memory model and monitors
	//*********************************************************************
	always @(posedge CLK) begin
		if (rand_waits && wait_run < WAIT_MAX && ($random(seed) & 3) == 0) begin
			bus_wait <= 1'b1;
			wait_run <= wait_run + 1;
		end else begin
			bus_wait <= 1'b0;
			wait_run <= 0;
		end
	end

	// Program image reloads while in reset
	always @(posedge CLK) begin
		if (!RST_N) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				if (i < PROG_LEN / 2)
					mem[i] <= {prog_ir[2 * i], prog_ir[2 * i + 1]};
				else
					mem[i] <= {`SH_NOP_IR, `SH_NOP_IR};
			end
		end else if (bus_req && !bus_wait && bus_wr) begin
			for (int b = 0; b < 4; b++)
				if (bus_ba[b])
					mem[bus_a[8:2]][8 * b +: 8] <= bus_do[8 * b +: 8];
		end
	end

	always @(posedge CLK) begin
		logic [15:0] exp_ir;
		if (!RST_N) begin
			st_idx  <= 0;
			ret_cnt <= 0;
			ili_cnt <= 0;
		end else if (running && st_idx < NSTORES) begin
			if (retire_valid) begin
				exp_ir = is_illegal(ret_cnt) ? `SH_NOP_IR : prog_ir[ret_cnt];
				if (retire_ir !== exp_ir) begin
					$display("ERR retire[%0d] pass %0d: expected %h, actual %h",
						ret_cnt, pass, exp_ir, retire_ir);
					retire_errs++;
				end
				ret_cnt <= ret_cnt + 1;
			end
			if (ili)
				ili_cnt <= ili_cnt + 1;
			if (bus_req && !bus_wait && bus_wr) begin
				if (bus_a !== st_tab[st_idx][67:36]) begin
					$display("ERR %s store %0d addr pass %0d: expected %h, actual %h",
						store_group(st_idx), st_idx, pass, st_tab[st_idx][67:36], bus_a);
					store_errs++;
				end
				if (bus_do !== st_tab[st_idx][35:4]) begin
					$display("ERR %s store %0d data pass %0d: expected %h, actual %h",
						store_group(st_idx), st_idx, pass, st_tab[st_idx][35:4], bus_do);
					store_errs++;
				end
				if (bus_ba !== st_tab[st_idx][3:0]) begin
					$display("ERR %s store %0d lanes pass %0d: expected %h, actual %h",
						store_group(st_idx), st_idx, pass, st_tab[st_idx][3:0], bus_ba);
					store_errs++;
				end
				st_idx <= st_idx + 1;
			end
		end
	end

	// Per-pass watchdog
	initial begin
		forever begin
			@(posedge CLK);
			if (running) begin
				cyc++;
				if (cyc > LIMIT_CYC) begin
					$display("Timeout in pass %0d: stores %0d to %0d never came",
						pass, st_idx, NSTORES - 1);
					$display("Errors: store %0d, retire %0d, other %0d, assert %0d, timeout 1",
						store_errs, retire_errs, other_errs, dut.u_asserts.fail_cnt);
					$display("Result: FAILED");
					$finish;
				end
			end
		end
	end

	//*********************************************************************
	// Main sequence
	//*********************************************************************
	initial begin
		seed        = 32'h6dae76e6;
		RST_N       = 1'b0;
		bus_wait    = 1'b0;
		wait_run    = 0;
		rand_waits  = 1'b0;
		running     = 1'b0;
		store_errs  = 0;
		retire_errs = 0;
		other_errs  = 0;
		first_ret   = 0;
		load_tables();
		for (pass = 0; pass < NPASS; pass++) begin
			@(posedge CLK);
			RST_N      <= 1'b0;
			rand_waits <= (pass != 0);
			cyc        = 0;
			repeat (2) @(posedge CLK);
			RST_N   <= 1'b1;
			running = 1'b1;
			while (st_idx < NSTORES)
				@(posedge CLK);
			running = 1'b0;
			if (ret_cnt != PROG_LEN) begin
				$display("ERR retire count pass %0d: expected %0d, actual %0d",
					pass, PROG_LEN, ret_cnt);
				other_errs++;
			end
			if (pass == 0)
				first_ret = ret_cnt;
			else if (ret_cnt != first_ret) begin
				$display("ERR wait retire count pass %0d: expected %0d, actual %0d",
					pass, first_ret, ret_cnt);
				other_errs++;
			end
			if (ili_cnt != NILL) begin
				$display("ERR ili count pass %0d: expected %0d, actual %0d",
					pass, NILL, ili_cnt);
				other_errs++;
			end
		end
		$display("Errors: store %0d, retire %0d, other %0d, assert %0d, timeout 0",
			store_errs, retire_errs, other_errs, dut.u_asserts.fail_cnt);
		if (store_errs + retire_errs + other_errs + dut.u_asserts.fail_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/sh_pkg.sv
design/sh_ifs.sv
design/sh_bus_seq.sv
design/sh_pc.sv
design/sh_decoder.sv
design/sh_regfile.sv
design/sh_execute.sv
design/sh_core.sv
test/sh_core_asserts.sv
test/sh_core_tb.sv

// ==== Bender.yml ====
package:
  name: sh_core

sources:
  - include_dirs:
      - design
    files:
      - design/sh_pkg.sv
      - design/sh_ifs.sv
      - design/sh_bus_seq.sv
      - design/sh_pc.sv
      - design/sh_decoder.sv
      - design/sh_regfile.sv
      - design/sh_execute.sv
      - design/sh_core.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - test/sh_core_asserts.sv
      - test/sh_core_tb.sv
